// ==== Bender.yml ====
package:
  name: audio_mix

sources:
  - files:
      - src/audio_pkg.sv
      - src/host_cmd_port.sv
      - src/mix_input_stage.sv
      - src/stereo_blend_stage.sv
      - src/volume_clamp_stage.sv
      - src/audio_mix_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_audio_mix.sv

// ==== project.f ====
+incdir+tb
src/audio_pkg.sv
src/host_cmd_port.sv
src/mix_input_stage.sv
src/stereo_blend_stage.sv
src/volume_clamp_stage.sv
src/audio_mix_top.sv
tb/tb_audio_mix.sv

// ==== src/audio_mix_top.sv ====
`timescale 1ns/10ps

module audio_mix_top import audio_pkg::*; (
	input  logic       clk_sys,
	input  logic       resetd,

	input  sample_t    i_core_l,
	input  sample_t    i_core_r,
	input  sample_t    i_host_l,
	input  sample_t    i_host_r,
	input  logic       i_is_signed,
	input  mix_t       i_mix,

	input  logic       i_host_req,
	input  logic       i_host_sel,
	input  host_word_t i_host_data,
	output logic       o_host_ack,

	output sample_t    o_audio_l,
	output sample_t    o_audio_r
);

	att_t    att;

	wide_t   sum_l;
	wide_t   sum_r;
	sample_t pre_l;
	sample_t pre_r;
	wide_t   blend_l;
	wide_t   blend_r;

	//////////////////////////////////////////////////////////////
	// Host command port
	//////////////////////////////////////////////////////////////

	host_cmd_port u_host_cmd_port (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_host_req  (i_host_req),
		.i_host_sel  (i_host_sel),
		.i_host_data (i_host_data),
		.o_host_ack  (o_host_ack),
		.o_att       (att)
	);

	//////////////////////////////////////////////////////////////
	// Left channel
	//////////////////////////////////////////////////////////////

	mix_input_stage u_input_l (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_core      (i_core_l),
		.i_host_pcm  (i_host_l),
		.i_is_signed (i_is_signed),
		.o_sum       (sum_l),
		.o_pre       (pre_l)
	);

	// Right pre value feeds the left crossfeed
	stereo_blend_stage u_blend_l (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_sum       (sum_l),
		.i_other_pre (pre_r),
		.i_mix       (i_mix),
		.o_blend     (blend_l)
	);

	volume_clamp_stage u_volume_l (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_blend  (blend_l),
		.i_att    (att),
		.o_sample (o_audio_l)
	);

	//////////////////////////////////////////////////////////////
	// Right channel
	//////////////////////////////////////////////////////////////

	mix_input_stage u_input_r (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_core      (i_core_r),
		.i_host_pcm  (i_host_r),
		.i_is_signed (i_is_signed),
		.o_sum       (sum_r),
		.o_pre       (pre_r)
	);

	stereo_blend_stage u_blend_r (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_sum       (sum_r),
		.i_other_pre (pre_l),
		.i_mix       (i_mix),
		.o_blend     (blend_r)
	);

	volume_clamp_stage u_volume_r (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_blend  (blend_r),
		.i_att    (att),
		.o_sample (o_audio_r)
	);

endmodule

// ==== src/audio_pkg.sv ====
package audio_pkg;

	//////////////////////////////////////////////////////////////
	// Sample and control widths
	//////////////////////////////////////////////////////////////

	// One audio sample as seen on the core, host or output side
	typedef logic [15:0] sample_t;

	// Intermediate sum, one guard bit above a sample
	typedef logic signed [16:0] wide_t;

	// Attenuation code
	// Bit 4 mutes, bits 3:0 give the right-shift count
	typedef logic [4:0] att_t;

	// Word carried on the host command port
	typedef logic [15:0] host_word_t;

	//////////////////////////////////////////////////////////////
	// Enumerations
	//////////////////////////////////////////////////////////////

	// Crossfeed share of the opposite channel
	typedef enum logic [1:0] {
		mix_none    = 2'd0,
		mix_quarter = 2'd1,
		mix_half    = 2'd2,
		mix_full    = 2'd3
	} mix_t;

	// Host port transaction phase
	typedef enum logic {
		cmd_idle = 1'b0,
		cmd_data = 1'b1
	} cmd_state_t;

	//////////////////////////////////////////////////////////////
	// Host command codes
	//////////////////////////////////////////////////////////////

	localparam logic [7:0] CMD_VOLUME = 8'h26;

endpackage

// ==== src/host_cmd_port.sv ====
`timescale 1ns/10ps

module host_cmd_port import audio_pkg::*; (
	input  logic       clk_sys,
	input  logic       resetd,

	input  logic       i_host_req,
	input  logic       i_host_sel,
	input  host_word_t i_host_data,

	output logic       o_host_ack,
	output att_t       o_att
);

	//////////////////////////////////////////////////////////////
	// Handshake
	//////////////////////////////////////////////////////////////

	// First stage of the acknowledge chain, also the edge reference
	logic req_q;
	logic ack_q;

	// High for the single cycle in which a new word is accepted
	logic word_take;

	assign word_take = i_host_req & ~req_q;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			req_q <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			req_q <= i_host_req;
			ack_q <= req_q;
		end
	end

	assign o_host_ack = ack_q;

	//////////////////////////////////////////////////////////////
	// Command decoder
	//////////////////////////////////////////////////////////////

	cmd_state_t state;
	logic [7:0] cmd_q;
	att_t       att_q;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state <= cmd_idle;
			cmd_q <= 8'd0;
			att_q <= '0;
		end else if (!i_host_sel) begin
			// Deselect ends the transaction
			state <= cmd_idle;
			cmd_q <= 8'd0;
		end else if (word_take) begin
			case (state)
				cmd_idle: begin
					// Only the low byte carries the command code
					cmd_q <= i_host_data[7:0];
					state <= cmd_data;
				end
				cmd_data: begin
					if (cmd_q == CMD_VOLUME) begin
						att_q <= i_host_data[4:0];
					end
				end
				default: begin
					state <= cmd_idle;
				end
			endcase
		end
	end

	assign o_att = att_q;

	//////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////

	// Acknowledge is a two-cycle echo of request
	a_ack_follows_req: assert property (
		@(posedge clk_sys) disable iff (resetd)
		$rose(o_host_ack) |-> $past(i_host_req, 2)
	) else $error("host ack rose without a request two cycles earlier");

endmodule

// ==== src/mix_input_stage.sv ====
`timescale 1ns/10ps

module mix_input_stage import audio_pkg::*; (
	input  logic    clk_sys,
	input  logic    resetd,

	input  sample_t i_core,
	input  sample_t i_host_pcm,
	input  logic    i_is_signed,

	output wide_t   o_sum,
	output sample_t o_pre
);

	//////////////////////////////////////////////////////////////
	// Core sample deglitch
	//////////////////////////////////////////////////////////////

	sample_t core_d1;
	sample_t core_d2;
	sample_t core_d3;
	sample_t core_held;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			core_d1   <= '0;
			core_d2   <= '0;
			core_d3   <= '0;
			core_held <= '0;
		end else begin
			core_d1 <= i_core;
			core_d2 <= core_d1;
			core_d3 <= core_d2;
			// Pass on only values seen twice in a row
			if (core_d2 == core_d3) begin
				core_held <= core_d2;
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// Alignment and host PCM sum
	//////////////////////////////////////////////////////////////

	wide_t aligned_q;
	wide_t sum_q;
	sample_t pre_q;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			aligned_q <= '0;
			sum_q     <= '0;
			pre_q     <= '0;
		end else begin
			// Unsigned input is halved to fit under the sign bit
			aligned_q <= i_is_signed ? {core_held[15], core_held}
			                         : {2'b00, core_held[15:1]};
			sum_q     <= aligned_q + {i_host_pcm[15], i_host_pcm};
			pre_q     <= sum_q[16:1];
		end
	end

	assign o_sum = sum_q;
	assign o_pre = pre_q;

endmodule

// ==== src/stereo_blend_stage.sv ====
`timescale 1ns/10ps

module stereo_blend_stage import audio_pkg::*; (
	input  logic    clk_sys,
	input  logic    resetd,

	input  wide_t   i_sum,
	input  sample_t i_other_pre,
	input  mix_t    i_mix,

	output wide_t   o_blend
);

	// Opposite channel widened with its sign
	wide_t other_ext;
	wide_t blend_next;
	wide_t blend_q;

	assign other_ext = {i_other_pre[15], i_other_pre};

	//////////////////////////////////////////////////////////////
	// Crossfeed selection
	//////////////////////////////////////////////////////////////

	always_comb begin
		case (i_mix)
			mix_none: begin
				blend_next = i_sum;
			end
			mix_quarter: begin
				// Give up an eighth, take a quarter of the other side
				blend_next = i_sum - (i_sum >>> 3) + (other_ext >>> 2);
			end
			mix_half: begin
				blend_next = i_sum - (i_sum >>> 2) + (other_ext >>> 1);
			end
			mix_full: begin
				// Plain average of both channels
				blend_next = (i_sum >>> 1) + other_ext;
			end
			default: begin
				blend_next = i_sum;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			blend_q <= '0;
		end else begin
			blend_q <= blend_next;
		end
	end

	assign o_blend = blend_q;

endmodule

// ==== src/volume_clamp_stage.sv ====
`timescale 1ns/10ps

module volume_clamp_stage import audio_pkg::*; (
	input  logic    clk_sys,
	input  logic    resetd,

	input  wide_t   i_blend,
	input  att_t    i_att,

	output sample_t o_sample
);

	wide_t   scaled_q;
	sample_t sample_q;
	logic    overflow;

	//////////////////////////////////////////////////////////////
	// Attenuation
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			scaled_q <= '0;
		end else if (i_att[4]) begin
			scaled_q <= '0;
		end else begin
			scaled_q <= i_blend >>> i_att[3:0];
		end
	end

	//////////////////////////////////////////////////////////////
	// Saturation
	//////////////////////////////////////////////////////////////

	// Guard bit and sign bit disagree
	assign overflow = scaled_q[16] ^ scaled_q[15];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sample_q <= '0;
		end else if (overflow) begin
			sample_q <= {scaled_q[16], {15{scaled_q[15]}}};
		end else begin
			sample_q <= scaled_q[15:0];
		end
	end

	assign o_sample = sample_q;

	a_clamp_on_overflow: assert property (
		@(posedge clk_sys) disable iff (resetd)
		overflow |=> (o_sample == 16'h7fff || o_sample == 16'h8000)
	) else $error("overflowed value reached the output unclamped");

endmodule

// ==== tb/tb_audio_mix_ref.svh ====
`ifndef TB_AUDIO_MIX_REF_SVH
`define TB_AUDIO_MIX_REF_SVH

//////////////////////////////////////////////////////////////
// Expected channel output for inputs held until settled
//////////////////////////////////////////////////////////////

// Input stage result as a plain signed number
function automatic int input_sum(sample_t core, sample_t host, bit signed_mode);
	int aligned;
	int host_val;
	if (signed_mode) begin
		aligned = $signed(core);
	end else begin
		// Unsigned core is halved so it stays under the sign bit
		aligned = core >> 1;
	end
	host_val = $signed(host);
	return aligned + host_val;
endfunction

function automatic sample_t ref_channel(sample_t core_own, sample_t core_other,
                                        sample_t host_own, sample_t host_other,
                                        bit signed_mode, mix_t mode, att_t att);
	int own_sum;
	int other_pre;
	int blend;
	int scaled;
	own_sum = input_sum(core_own, host_own, signed_mode);
	// Pre value is the other sum without its lowest bit
	other_pre = input_sum(core_other, host_other, signed_mode) >>> 1;
	case (mode)
		mix_quarter: blend = own_sum - (own_sum >>> 3) + (other_pre >>> 2);
		mix_half:    blend = own_sum - (own_sum >>> 2) + (other_pre >>> 1);
		mix_full:    blend = (own_sum >>> 1) + other_pre;
		default:     blend = own_sum;
	endcase
	if (att[4]) begin
		return '0;
	end
	scaled = blend >>> att[3:0];
	// Clamp anything outside the 16-bit signed range
	if (scaled > 32767) begin
		return 16'h7fff;
	end
	if (scaled < -32768) begin
		return 16'h8000;
	end
	return scaled[15:0];
endfunction

`endif

// ==== tb/tb_audio_mix.sv ====
`timescale 1ns/10ps

module tb_audio_mix import audio_pkg::*; ();

	localparam int NUM_MIX   = 32;
	localparam int NUM_VOL   = 17;
	localparam int NUM_TESTS = NUM_MIX + NUM_VOL + 10;
	localparam int SETTLE    = 12;
	localparam int LIMIT_NS  = 2 * NUM_TESTS * 40 * 20;

	logic       clk_sys;
	logic       resetd;
	sample_t    core_l;
	sample_t    core_r;
	sample_t    host_l;
	sample_t    host_r;
	logic       is_signed;
	mix_t       mix;
	logic       host_req;
	logic       host_sel;
	host_word_t host_data;
	logic       host_ack;
	sample_t    audio_l;
	sample_t    audio_r;

	att_t    att_model;
	sample_t exp_l;
	sample_t exp_r;
	bit      use_att_check;
	bit      watch_each_cycle;
	string   case_name;
	int      seed;
	int      sample_errors;
	int      att_errors;
	int      ack_errors;
	event    compare_start;
	event    compare_end;

	audio_mix_top u_audio_mix_top (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_core_l    (core_l),
		.i_core_r    (core_r),
		.i_host_l    (host_l),
		.i_host_r    (host_r),
		.i_is_signed (is_signed),
		.i_mix       (mix),
		.i_host_req  (host_req),
		.i_host_sel  (host_sel),
		.i_host_data (host_data),
		.o_host_ack  (host_ack),
		.o_audio_l   (audio_l),
		.o_audio_r   (audio_r)
	);

	`include "tb_audio_mix_ref.svh"

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////

	task automatic check_sample(input sample_t got, input sample_t exp, input string what);
		if (got !== exp) begin
			sample_errors++;
			$display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_att_effect(input sample_t got_l, input sample_t got_r,
	                                input sample_t want_l, input sample_t want_r,
	                                input string what);
		if (got_l !== want_l || got_r !== want_r) begin
			att_errors++;
			$display("error at %0t ns: %s, got %h/%h, expected %h/%h",
			         $time, what, got_l, got_r, want_l, want_r);
		end
	endtask

	task automatic check_ack(input bit got, input bit exp, input string what);
		if (got !== exp) begin
			ack_errors++;
			$display("error at %0t ns: %s, ack is %b, expected %b", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////

	task automatic next_drive();
		@(posedge clk_sys);
		#2;
	endtask

	// Ack is expected two rising edges after req changes
	task automatic wait_ack(input bit level, input string what);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk_sys);
			cycles++;
			@(negedge clk_sys);
		end while (host_ack !== level && cycles < 8);
		check_ack(host_ack, level, what);
		if (cycles != 2) begin
			ack_errors++;
			$display("error at %0t ns: %s after %0d cycles, expected 2", $time, what, cycles);
		end
	endtask

	task automatic host_write(input host_word_t word);
		next_drive();
		host_data = word;
		host_req  = 1'b1;
		wait_ack(1'b1, "ack rise");
		next_drive();
		host_req = 1'b0;
		wait_ack(1'b0, "ack fall");
	endtask

	task automatic host_command(input host_word_t cmd, input host_word_t data);
		next_drive();
		host_sel = 1'b1;
		host_write(cmd);
		host_write(data);
		next_drive();
		host_sel = 1'b0;
	endtask

	// High byte of the command word is noise, only the low byte decodes
	task automatic set_volume(input att_t att);
		host_command({8'hc3, CMD_VOLUME}, {11'h2a5, att});
		att_model = att;
	endtask

	task automatic expect_ref();
		exp_l = ref_channel(core_l, core_r, host_l, host_r, is_signed, mix, att_model);
		exp_r = ref_channel(core_r, core_l, host_r, host_l, is_signed, mix, att_model);
	endtask

	task automatic run_compare(input bit att_kind, input string what);
		use_att_check = att_kind;
		case_name     = what;
		-> compare_start;
		@(compare_end);
	endtask

	task automatic random_samples();
		core_l = $random(seed);
		core_r = $random(seed);
		host_l = $random(seed);
		host_r = $random(seed);
	endtask

	//////////////////////////////////////////////////////////////
	// Comparison after each settle window
	//////////////////////////////////////////////////////////////

	initial begin
		int n;
		forever begin
			@(compare_start);
			for (n = 1; n <= SETTLE; n++) begin
				@(posedge clk_sys);
				@(negedge clk_sys);
				// Held outputs are watched on every cycle of the window
				if (watch_each_cycle || n == SETTLE) begin
					if (use_att_check) begin
						check_att_effect(audio_l, audio_r, exp_l, exp_r, case_name);
					end else begin
						check_sample(audio_l, exp_l, {case_name, " left"});
						check_sample(audio_r, exp_r, {case_name, " right"});
					end
				end
			end
			-> compare_end;
		end
	end

	//////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////

	initial begin
		int i;
		resetd           = 1'b1;
		core_l           = '0;
		core_r           = '0;
		host_l           = '0;
		host_r           = '0;
		is_signed        = 1'b0;
		mix              = mix_none;
		host_req         = 1'b0;
		host_sel         = 1'b0;
		host_data        = '0;
		att_model        = '0;
		exp_l            = '0;
		exp_r            = '0;
		use_att_check    = 1'b0;
		watch_each_cycle = 1'b0;
		case_name        = "";
		seed             = 86;
		sample_errors    = 0;
		att_errors       = 0;
		ack_errors       = 0;

		repeat (4) @(posedge clk_sys);
		#2;
		resetd = 1'b0;
		@(negedge clk_sys);
		check_ack(host_ack, 1'b0, "ack after reset");
		check_sample(audio_l, '0, "left after reset");
		check_sample(audio_r, '0, "right after reset");

		// All blend modes, signed and unsigned in turn
		for (i = 0; i < NUM_MIX; i++) begin
			next_drive();
			mix       = mix_t'(i % 4);
			is_signed = ((i / 4) % 2) == 1;
			random_samples();
			expect_ref();
			run_compare(1'b0, $sformatf("mix case %0d", i));
		end

		// Every shift count, then mute with shift bits set
		next_drive();
		mix       = mix_half;
		is_signed = 1'b1;
		random_samples();
		for (i = 0; i < 16; i++) begin
			set_volume(att_t'(i));
			expect_ref();
			run_compare(1'b1, $sformatf("volume shift %0d", i));
		end
		set_volume(5'h1a);
		expect_ref();
		run_compare(1'b1, "volume mute");

		// Full scale sums must clamp
		set_volume('0);
		next_drive();
		mix    = mix_none;
		core_l = 16'h7fff;
		host_l = 16'h7fff;
		core_r = 16'h8000;
		host_r = 16'h8000;
		exp_l  = 16'h7fff;
		exp_r  = 16'h8000;
		run_compare(1'b1, "clamp positive left");
		next_drive();
		core_l = 16'h8000;
		host_l = 16'h8000;
		core_r = 16'h7fff;
		host_r = 16'h7fff;
		exp_l  = 16'h8000;
		exp_r  = 16'h7fff;
		run_compare(1'b1, "clamp negative left");

		// Mute data under another command code
		next_drive();
		mix       = mix_full;
		is_signed = 1'b0;
		random_samples();
		expect_ref();
		run_compare(1'b0, "before other command");
		host_command(16'h0025, 16'h0010);
		run_compare(1'b0, "after other command");

		// One cycle glitch on both core inputs must never reach the outputs
		next_drive();
		mix       = mix_quarter;
		is_signed = 1'b1;
		random_samples();
		expect_ref();
		run_compare(1'b0, "glitch baseline");
		next_drive();
		core_l = ~core_l;
		core_r = core_r ^ 16'h5a5a;
		next_drive();
		core_l = ~core_l;
		core_r = core_r ^ 16'h5a5a;
		watch_each_cycle = 1'b1;
		run_compare(1'b0, "after glitch");
		watch_each_cycle = 1'b0;

		$display("Errors: sample %0d, volume %0d, handshake %0d",
		         sample_errors, att_errors, ack_errors);
		if (sample_errors + att_errors + ack_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(LIMIT_NS);
		$display("Timed out: the tests did not finish within %0d ns", LIMIT_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule
